// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_uart_top
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
uart_pkg.sv
word_if.sv
serial_rx_byte.sv
serial_rx.sv
serial_tx_byte.sv
serial_tx.sv
uart_apb_regs.sv
uart_top.sv
tb_uart_top.sv

// File: serial_rx.sv
////////////////////////////////////////
// word receiver
// collects NUM_BYTES frames, low byte
// first, into one word pulse
////////////////////////////////////////

`default_nettype none

module serial_rx
    import uart_pkg::*;
(
    input  logic clk,
    input  logic rst_in,
    input  logic line,
    word_if.rx_src word
);

    logic                  byte_valid;
    logic [7:0]            byte_data;
    logic                  byte_err;
    rx_word_state_e        state;
    logic [BYTE_CNT_W-1:0] byte_cnt;
    logic [WORD_W-1:0]     acc;
    logic                  acc_err;
    logic [WORD_W-1:0]     placed;
    logic [WORD_W-1:0]     merged;
    logic                  merged_err;
    logic                  last_byte;

    serial_rx_byte u_rx_byte (
        .clk       (clk),
        .rst_in    (rst_in),
        .line      (line),
        .valid     (byte_valid),
        .data      (byte_data),
        .frame_err (byte_err)
    );

    // byte lands at 8 * byte_cnt
    assign placed     = WORD_W'(byte_data) << {byte_cnt, 3'b000};
    assign merged     = (state == RXW_COLLECT) ? (acc | placed) : placed;
    assign merged_err = ((state == RXW_COLLECT) && acc_err) || byte_err;
    assign last_byte  = (byte_cnt == BYTE_CNT_W'(NUM_BYTES - 1));

    // word goes out in the cycle the last byte arrives
    assign word.valid = byte_valid && last_byte;
    assign word.data  = merged;
    assign word.err   = merged_err;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            state    <= RXW_IDLE;
            byte_cnt <= '0;
        end else if (byte_valid) begin
            if (last_byte) begin
                state    <= RXW_IDLE;
                byte_cnt <= '0;
            end else begin
                state    <= RXW_COLLECT;
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            acc     <= merged;
            acc_err <= merged_err;
        end
    end

endmodule

`default_nettype wire

// File: serial_rx_byte.sv
////////////////////////////////////////
// 8N1 frame receiver
// start bit check, mid-bit sampling,
// stop bit check with frame error
////////////////////////////////////////

`default_nettype none

module serial_rx_byte
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst_in,
    input  logic       line,
    output logic       valid,
    output logic [7:0] data,
    output logic       frame_err
);

    rx_byte_state_e   state;
    logic [2:0]       sync;
    logic             line_s;
    logic             line_fell;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             bit_done;

    // two stage synchronizer plus one delayed copy for edge detect
    assign line_s    = sync[1];
    assign line_fell = sync[2] && !sync[1];
    assign bit_done  = (cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst_in) begin
            sync      <= '1;
            state     <= RXB_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            valid     <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            sync  <= {sync[1:0], line};
            valid <= 1'b0;
            case (state)
                RXB_IDLE: begin
                    if (line_fell) begin
                        cnt   <= '0;
                        state <= RXB_START_BIT;
                    end
                end
                RXB_START_BIT: begin
                    // mid start bit, high again means noise
                    if (cnt == CNT_W'(HALF_BIT - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= line_s ? RXB_IDLE : RXB_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RXB_DATA: begin
                    if (bit_done) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RXB_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RXB_STOP: begin
                    if (bit_done) begin
                        cnt       <= '0;
                        frame_err <= !line_s;
                        valid     <= 1'b1;
                        state     <= RXB_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RXB_IDLE;
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == RXB_DATA && bit_done) begin
            data <= {line_s, data[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: serial_tx.sv
////////////////////////////////////////
// word transmitter
// sends NUM_BYTES frames, low byte first,
// one idle bit time between frames
////////////////////////////////////////

`default_nettype none

module serial_tx
    import uart_pkg::*;
(
    input  logic clk,
    input  logic rst_in,
    word_if.tx_snk word,
    output logic line
);

    tx_word_state_e        state;
    logic [WORD_W-1:0]     data_q;
    logic [BYTE_CNT_W-1:0] byte_cnt;
    logic [CNT_W-1:0]      gap_cnt;
    logic                  gap_done;
    logic                  byte_start;
    logic                  byte_ready;

    serial_tx_byte u_tx_byte (
        .clk    (clk),
        .rst_in (rst_in),
        .start  (byte_start),
        .data   (data_q[7:0]),
        .ready  (byte_ready),
        .line   (line)
    );

    assign word.ready = (state == TXW_IDLE);
    assign gap_done   = (gap_cnt == CNT_W'(CLKS_PER_BIT - 1));
    // next frame starts on the last gap cycle
    assign byte_start = ((state == TXW_LOAD) && byte_ready) ||
                        ((state == TXW_GAP) && gap_done);

    always_ff @(posedge clk) begin
        if (rst_in) begin
            state    <= TXW_IDLE;
            byte_cnt <= '0;
            gap_cnt  <= '0;
        end else begin
            case (state)
                TXW_IDLE: begin
                    if (word.valid) begin
                        byte_cnt <= '0;
                        state    <= TXW_LOAD;
                    end
                end
                TXW_LOAD: begin
                    if (byte_ready) begin
                        state <= TXW_SENDING;
                    end
                end
                TXW_SENDING: begin
                    if (byte_ready) begin
                        if (byte_cnt == BYTE_CNT_W'(NUM_BYTES - 1)) begin
                            state <= TXW_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            // first idle cycle was spent here
                            gap_cnt  <= CNT_W'(1);
                            state    <= TXW_GAP;
                        end
                    end
                end
                TXW_GAP: begin
                    if (gap_done) begin
                        state <= TXW_SENDING;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: state <= TXW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TXW_IDLE && word.valid) begin
            data_q <= word.data;
        end else if (byte_start) begin
            data_q <= data_q >> 8;
        end
    end

endmodule

`default_nettype wire

// File: serial_tx_byte.sv
////////////////////////////////////////
// 8N1 frame transmitter
// start bit, 8 data bits lsb first,
// stop bit
////////////////////////////////////////

`default_nettype none

module serial_tx_byte
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst_in,
    input  logic       start,
    input  logic [7:0] data,
    output logic       ready,
    output logic       line
);

    logic [8:0]       shift;
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_cnt;
    logic             bit_done;

    assign bit_done = (cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst_in) begin
            ready   <= 1'b1;
            line    <= 1'b1;
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (ready) begin
            // start bit goes out right away
            if (start) begin
                ready   <= 1'b0;
                line    <= 1'b0;
                cnt     <= '0;
                bit_cnt <= '0;
            end
        end else if (bit_done) begin
            cnt <= '0;
            if (bit_cnt == 4'd9) begin
                // end of stop bit, line is already high
                ready <= 1'b1;
            end else begin
                line    <= shift[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // data bits then stop bit, refilled with idle ones
    always_ff @(posedge clk) begin
        if (ready && start) begin
            shift <= {1'b1, data};
        end else if (!ready && bit_done) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

    a_start_when_ready: assert property (@(posedge clk) disable iff (rst_in)
        start |-> ready);

endmodule

`default_nettype wire

// File: tb_uart_top.sv
////////////////////////////////////////
// testbench for the UART top level
// golden file operations, APB tasks,
// loopback and driven serial frames
////////////////////////////////////////

`default_nettype none

module tb_uart_top
    import uart_pkg::*;
();

    localparam int          CLK_PERIOD  = 4;
    localparam logic [31:0] SEED        = 32'h1ceeb36e;
    localparam int          MAX_POLLS   = 600;
    localparam string       GOLDEN_FILE = "uart_golden.txt";

    logic        clk;
    logic        rst_in;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;
    logic        rx_line;
    logic        tx_line;
    logic        loopback;
    logic        drv_line;

    // rx comes from tx or from frames driven here
    assign rx_line = loopback ? tx_line : drv_line;

    uart_top DUT (
        .clk     (clk),
        .rst_in  (rst_in),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .rx_line (rx_line),
        .tx_line (tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // reporting
    ////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("Mismatch at %0t: %s expected %h actual %h",
                               $time, name, expected, actual));
        end
    endtask

    ////////////////////////////////////////
    // APB access
    ////////////////////////////////////////

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(negedge clk);
        penable <= 1'b1;
        // sample mid access cycle
        #(CLK_PERIOD / 4);
        err = pslverr;
        @(negedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(negedge clk);
        penable <= 1'b1;
        #(CLK_PERIOD / 4);
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_status(input int bit_pos, input logic value, input string what);
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(STATUS, st, err);
        while (st[bit_pos] !== value) begin
            polls++;
            if (polls > MAX_POLLS) begin
                fail_run({"timed out waiting for ", what});
            end
            apb_read(STATUS, st, err);
        end
    endtask

    task automatic check_status(input logic [31:0] expected);
        logic [31:0] st;
        logic        err;
        apb_read(STATUS, st, err);
        check_value("pslverr", 32'd0, 32'(err));
        check_value("STATUS", expected, st);
    endtask

    task automatic send_word(input logic [31:0] w);
        logic err;
        apb_write(TXDATA, w, err);
        check_value("pslverr", 32'd0, 32'(err));
    endtask

    // read RXDATA, then rx_full has to be clear
    task automatic read_rx_expect(input logic [31:0] w);
        logic [31:0] d;
        logic        err;
        apb_read(RXDATA, d, err);
        check_value("pslverr", 32'd0, 32'(err));
        check_value("RXDATA", w, d);
        apb_read(STATUS, d, err);
        check_value("rx_full", 32'd0, 32'(d[STATUS_RX_FULL]));
    endtask

    ////////////////////////////////////////
    // serial frames driven by the testbench
    ////////////////////////////////////////

    task automatic drive_bit(input logic v);
        repeat (CLKS_PER_BIT) begin
            @(negedge clk);
            drv_line <= v;
        end
    endtask

    task automatic drive_frame(input logic [7:0] b, input logic stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(stop);
        // idle bit time between frames
        drive_bit(1'b1);
    endtask

    ////////////////////////////////////////
    // golden file operations
    ////////////////////////////////////////

    task automatic run_loopback(input logic [31:0] w);
        wait_status(STATUS_TX_BUSY, 1'b0, "transmitter idle");
        send_word(w);
        wait_status(STATUS_RX_FULL, 1'b1, "received word");
        read_rx_expect(w);
    endtask

    task automatic run_overrun(input logic [31:0] w1, input logic [31:0] w2);
        wait_status(STATUS_TX_BUSY, 1'b0, "transmitter idle");
        send_word(w1);
        wait_status(STATUS_RX_FULL, 1'b1, "first word");
        wait_status(STATUS_TX_BUSY, 1'b0, "transmitter idle");
        send_word(w2);
        wait_status(STATUS_OVERRUN, 1'b1, "overrun flag");
        // second word dropped, first one kept
        read_rx_expect(w1);
    endtask

    task automatic run_bad_stop(input logic [31:0] w);
        logic [31:0] st;
        logic        err;
        wait_status(STATUS_TX_BUSY, 1'b0, "transmitter idle");
        @(negedge clk);
        loopback <= 1'b0;
        for (int k = 0; k < NUM_BYTES; k++) begin
            drive_frame(w[8*k +: 8], k != 1);
        end
        wait_status(STATUS_RX_FULL, 1'b1, "word with bad stop bit");
        apb_read(STATUS, st, err);
        check_value("frame_err", 32'd1, 32'(st[STATUS_FRAME_ERR]));
        read_rx_expect(w);
        @(negedge clk);
        loopback <= 1'b1;
    endtask

    task automatic run_clear(input logic [31:0] expected);
        logic err;
        wait_status(STATUS_TX_BUSY, 1'b0, "transmitter idle");
        check_status(expected);
        // zeros leave the sticky flags alone
        apb_write(STATUS, 32'd0, err);
        check_value("pslverr", 32'd0, 32'(err));
        check_status(expected);
        apb_write(STATUS, 32'hffff_ffff, err);
        check_value("pslverr", 32'd0, 32'(err));
        check_status(32'd0);
    endtask

    task automatic run_error(input logic [7:0] addr, input logic wr, input logic [31:0] data);
        logic [31:0] w;
        logic [31:0] d;
        logic        err;
        if (addr == TXDATA && wr) begin
            w = $urandom();
            wait_status(STATUS_TX_BUSY, 1'b0, "transmitter idle");
            send_word(w);
            apb_write(TXDATA, data, err);
            check_value("pslverr", 32'd1, 32'(err));
            wait_status(STATUS_RX_FULL, 1'b1, "word sent before rejected write");
            read_rx_expect(w);
        end else if (addr == RXDATA && !wr) begin
            apb_read(addr, d, err);
            check_value("pslverr", 32'd1, 32'(err));
        end else if (wr) begin
            apb_write(addr, data, err);
            check_value("pslverr", 32'd1, 32'(err));
        end else begin
            apb_read(addr, d, err);
            check_value("pslverr", 32'd1, 32'(err));
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          num_ops;
        string       line;
        string       op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        rst_in   = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        loopback = 1'b1;
        drv_line = 1'b1;
        num_ops  = 0;
        void'($urandom(SEED));
        repeat (8) @(negedge clk);
        rst_in <= 1'b0;
        @(negedge clk);
        check_value("tx_line", 32'd1, 32'(tx_line));
        check_value("pslverr", 32'd0, 32'(pslverr));
        check_value("prdata", 32'd0, prdata);
        check_status(32'd0);

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            fail_run("could not open the golden file");
        end
        while ($fgets(line, fd) != 0) begin
            op = "";
            n  = $sscanf(line, "%s %h %h %h", op, f1, f2, f3);
            if (n < 1 || op.substr(0, 0) == "#") begin
                continue;
            end
            num_ops++;
            if (op == "L") begin
                if (n < 2) begin
                    f1 = $urandom();
                end
                run_loopback(f1);
            end else if (op == "O") begin
                run_overrun(f1, f2);
            end else if (op == "F") begin
                run_bad_stop(f1);
            end else if (op == "E") begin
                run_error(f1[7:0], f2[0], f3);
            end else if (op == "C") begin
                run_clear(f1);
            end else begin
                fail_run({"unknown operation in golden file: ", op});
            end
        end
        $fclose(fd);
        if (num_ops == 0) begin
            fail_run("golden file held no operations");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: uart_apb_regs.sv
////////////////////////////////////////
// APB slave register block
// TXDATA, RXDATA and STATUS registers,
// overrun and framing error flags
////////////////////////////////////////

`default_nettype none

module uart_apb_regs
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        rst_in,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    word_if.rx_snk      rx_word,
    word_if.tx_src      tx_word
);

    reg_addr_e         addr;
    logic              access;
    logic              tx_busy;
    logic              wr_tx;
    logic              rd_rx;
    logic              clr_overrun;
    logic              clr_frame_err;
    logic [WORD_W-1:0] rx_data;
    logic              rx_full;
    logic              overrun;
    logic              frame_err;
    logic [31:0]       status;

    assign addr    = reg_addr_e'(paddr);
    assign access  = psel && penable;
    assign tx_busy = !tx_word.ready;

    assign tx_word.valid = wr_tx;
    assign tx_word.data  = pwdata;

    always_comb begin
        status                   = '0;
        status[STATUS_TX_BUSY]   = tx_busy;
        status[STATUS_RX_FULL]   = rx_full;
        status[STATUS_OVERRUN]   = overrun;
        status[STATUS_FRAME_ERR] = frame_err;
    end

    ////////////////////////////////////////
    // access decode
    ////////////////////////////////////////

    always_comb begin
        prdata        = '0;
        pslverr       = 1'b0;
        wr_tx         = 1'b0;
        rd_rx         = 1'b0;
        clr_overrun   = 1'b0;
        clr_frame_err = 1'b0;
        if (access) begin
            case (addr)
                TXDATA: begin
                    if (pwrite) begin
                        pslverr = tx_busy;
                        wr_tx   = !tx_busy;
                    end
                end
                RXDATA: begin
                    // read only, reading empty is an error
                    if (!pwrite) begin
                        pslverr = !rx_full;
                        rd_rx   = rx_full;
                        prdata  = rx_full ? rx_data : '0;
                    end
                end
                STATUS: begin
                    if (pwrite) begin
                        clr_overrun   = pwdata[STATUS_OVERRUN];
                        clr_frame_err = pwdata[STATUS_FRAME_ERR];
                    end else begin
                        prdata = status;
                    end
                end
                default: pslverr = 1'b1;
            endcase
        end
    end

    ////////////////////////////////////////
    // receive word and sticky flags
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_in) begin
            rx_full   <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            // a read in the same cycle frees the slot
            if (rx_word.valid && (!rx_full || rd_rx)) begin
                rx_full <= 1'b1;
            end else if (rd_rx) begin
                rx_full <= 1'b0;
            end
            overrun   <= (overrun && !clr_overrun) ||
                         (rx_word.valid && rx_full && !rd_rx);
            frame_err <= (frame_err && !clr_frame_err) ||
                         (rx_word.valid && rx_word.err);
        end
    end

    always_ff @(posedge clk) begin
        if (rx_word.valid && (!rx_full || rd_rx)) begin
            rx_data <= rx_word.data;
        end
    end

    a_setup_before_access: assert property (@(posedge clk) disable iff (rst_in)
        $rose(penable) |-> psel && $past(psel));

endmodule

`default_nettype wire

// File: uart_golden.txt
# op L: word (none = random) | O: word1 word2 | F: word with bad second stop bit
# op E: addr write data | C: STATUS expected before clear, all fields hex
L 00000000
L ffffffff
L a5c3e17b
L 12345678
L
L
L
O 0badf00d c0ffee11
C 00000004
F 8e7d6c5b
C 00000008
O 13572468 deadbeef
F 00ff55aa
C 0000000c
E 04 0 00000000
E 0c 0 00000000
E 10 1 00000000
E 00 1 55555555
E fc 0 00000000
L 80000001
L
L 7f00ff01

// File: uart_pkg.sv
////////////////////////////////////////
// shared constants and types for the UART
// bit timing, word size, register map,
// STATUS bit positions and FSM states
////////////////////////////////////////

`default_nettype none

package uart_pkg;

    // bit timing
    localparam int CLKS_PER_BIT = 8;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    // word layout
    localparam int NUM_BYTES    = 4;
    localparam int BYTE_CNT_W   = $clog2(NUM_BYTES);
    localparam int WORD_W       = NUM_BYTES * 8;

    // STATUS register bits
    localparam int STATUS_TX_BUSY   = 0;
    localparam int STATUS_RX_FULL   = 1;
    localparam int STATUS_OVERRUN   = 2;
    localparam int STATUS_FRAME_ERR = 3;

    typedef enum logic [7:0] {
        TXDATA = 8'h00,
        RXDATA = 8'h04,
        STATUS = 8'h08
    } reg_addr_e;

    typedef enum logic [1:0] {RXB_IDLE, RXB_START_BIT, RXB_DATA, RXB_STOP} rx_byte_state_e;
    typedef enum logic {RXW_IDLE, RXW_COLLECT} rx_word_state_e;
    typedef enum logic [1:0] {TXW_IDLE, TXW_LOAD, TXW_SENDING, TXW_GAP} tx_word_state_e;

endpackage

`default_nettype wire

// File: uart_top.sv
////////////////////////////////////////
// UART top level
// APB registers with serial rx and tx
////////////////////////////////////////

`default_nettype none

module uart_top (
    input  logic        clk,
    input  logic        rst_in,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    input  logic        rx_line,
    output logic        tx_line
);

    // received word pulse and transmit request
    word_if rx_word ();
    word_if tx_word ();

    serial_rx u_serial_rx (
        .clk    (clk),
        .rst_in (rst_in),
        .line   (rx_line),
        .word   (rx_word)
    );

    serial_tx u_serial_tx (
        .clk    (clk),
        .rst_in (rst_in),
        .word   (tx_word),
        .line   (tx_line)
    );

    uart_apb_regs u_regs (
        .clk     (clk),
        .rst_in  (rst_in),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .rx_word (rx_word),
        .tx_word (tx_word)
    );

endmodule

`default_nettype wire

// File: word_if.sv
////////////////////////////////////////
// word transfer interface
// receive pulse and transmit handshake
////////////////////////////////////////

`default_nettype none

interface word_if
    import uart_pkg::*;
();
    logic              valid;
    logic              ready;
    logic [WORD_W-1:0] data;
    logic              err;

    // receive side is a pulse, no ready
    modport rx_src (output valid, data, err);
    modport rx_snk (input valid, data, err);

    // transmit side hands over on valid and ready
    modport tx_src (output valid, data, input ready);
    modport tx_snk (input valid, data, output ready);
endinterface

`default_nettype wire
